//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pipe_backend
FILELIST = sources.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- execute_unit.sv
// ########################################
// EX stage: operand forwarding, ALU, set, lbi and slbi
// results are held in the EX/MEM register
// ########################################
`timescale 1ns/1ps
`include "pipe_macros.svh"

module execute_unit
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  id_ex_t  id_ex,
    input  mem_wb_t mem_wb, // needed for MEM/WB forwarding
    output ex_mem_t ex_mem
);

    logic  ex_fwd_rs;
    logic  ex_fwd_rt;
    logic  mem_fwd_rs;
    logic  mem_fwd_rt;
    word_t ex_rs;
    word_t ex_rt;
    word_t mem_rs;
    word_t mem_rt;
    word_t op_a;
    word_t op_b;
    word_t imm_sext;
    word_t alu_res;
    word_t set_res;
    word_t slbi_res;

    forward u_forward (
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .ex_fwd_rs  (ex_fwd_rs),
        .ex_fwd_rt  (ex_fwd_rt),
        .mem_fwd_rs (mem_fwd_rs),
        .mem_fwd_rt (mem_fwd_rt),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .mem_rs     (mem_rs),
        .mem_rt     (mem_rt)
    );

    assign op_a = ex_fwd_rs ? ex_rs : (mem_fwd_rs ? mem_rs : id_ex.rs_val);
    assign op_b = ex_fwd_rt ? ex_rt : (mem_fwd_rt ? mem_rt : id_ex.rt_val);

    assign imm_sext = {{(`DATA_WIDTH-IMM_WIDTH){id_ex.dec.imm[IMM_WIDTH-1]}}, id_ex.dec.imm};
    assign slbi_res = (op_a << 8) | {{(`DATA_WIDTH-IMM_WIDTH){1'b0}}, id_ex.dec.imm};

    always_comb begin
        case (id_ex.dec.op)
            op_sub:       alu_res = op_a - op_b;
            op_xor:       alu_res = op_a ^ op_b;
            op_and:       alu_res = op_a & op_b;
            op_ld, op_st: alu_res = op_a + imm_sext; // effective address
            default:      alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        set_res = '0;
        if (id_ex.dec.op == op_seq) begin
            set_res[0] = (op_a == op_b);
        end else if (id_ex.dec.op == op_slt) begin
            set_res[0] = ($signed(op_a) < $signed(op_b));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.rd       <= id_ex.dec.rd;
            ex_mem.wr_en    <= id_ex.dec.wr_en;
            ex_mem.wr_sel   <= id_ex.dec.wr_sel;
            ex_mem.op       <= id_ex.dec.op;
            ex_mem.st_data  <= op_b; // store data sees forwarded rt
            ex_mem.alu_res  <= alu_res;
            ex_mem.set_res  <= set_res;
            ex_mem.lbi_res  <= imm_sext;
            ex_mem.slbi_res <= slbi_res;
        end
    end

endmodule

//--- forward.sv
// ########################################
// data hazard detection for the EX stage
// EX/MEM matches win over MEM/WB matches
// ########################################
`timescale 1ns/1ps

module forward
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  id_ex_t  id_ex,
    input  ex_mem_t ex_mem,
    input  mem_wb_t mem_wb,
    output logic    ex_fwd_rs,  // rs taken from EX/MEM
    output logic    ex_fwd_rt,
    output logic    mem_fwd_rs, // rs taken from MEM/WB
    output logic    mem_fwd_rt,
    output word_t   ex_rs,      // forwarded values, zero when not forwarding
    output word_t   ex_rt,
    output word_t   mem_rs,
    output word_t   mem_rt
);

    word_t ex_wr_data;
    word_t mem_wr_data;

    assign ex_fwd_rs = ex_mem.wr_en && (ex_mem.rd == id_ex.dec.rs);
    assign ex_fwd_rt = ex_mem.wr_en && id_ex.dec.has_rt && (ex_mem.rd == id_ex.dec.rt);

    // only when the newer EX/MEM result does not already cover the source
    assign mem_fwd_rs = mem_wb.wr_en && (mem_wb.rd == id_ex.dec.rs) && !ex_fwd_rs;
    assign mem_fwd_rt = mem_wb.wr_en && id_ex.dec.has_rt && (mem_wb.rd == id_ex.dec.rt)
                        && !ex_fwd_rt;

    always_comb begin
        case (ex_mem.wr_sel)
            wsel_alu:  ex_wr_data = ex_mem.alu_res;
            wsel_set:  ex_wr_data = ex_mem.set_res;
            wsel_lbi:  ex_wr_data = ex_mem.lbi_res;
            wsel_slbi: ex_wr_data = ex_mem.slbi_res;
            default:   ex_wr_data = '0; // load data is not ready in EX/MEM
        endcase
    end

    always_comb begin
        case (mem_wb.wr_sel)
            wsel_alu:  mem_wr_data = mem_wb.alu_res;
            wsel_mem:  mem_wr_data = mem_wb.mem_res;
            wsel_set:  mem_wr_data = mem_wb.set_res;
            wsel_lbi:  mem_wr_data = mem_wb.lbi_res;
            wsel_slbi: mem_wr_data = mem_wb.slbi_res;
            default:   mem_wr_data = '0;
        endcase
    end

    assign ex_rs  = ex_fwd_rs  ? ex_wr_data  : '0;
    assign ex_rt  = ex_fwd_rt  ? ex_wr_data  : '0;
    assign mem_rs = mem_fwd_rs ? mem_wr_data : '0;
    assign mem_rt = mem_fwd_rt ? mem_wr_data : '0;

endmodule

//--- isa_pkg.sv
// ########################################
// instruction level types shared by the back end
// operation codes, write-select codes, decoded operation
// ########################################
`include "pipe_macros.svh"

package isa_pkg;

    localparam int IMM_WIDTH = 8;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    typedef logic [`DATA_WIDTH-1:0] word_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_xor = 3'd2,
        op_and = 3'd3,
        op_seq = 3'd4,
        op_slt = 3'd5, // signed compare
        op_ld  = 3'd6,
        op_st  = 3'd7
    } op_e;

    // codes 2, 6 and 7 are unused
    typedef enum logic [2:0] {
        wsel_alu  = 3'd0,
        wsel_mem  = 3'd1,
        wsel_set  = 3'd3,
        wsel_lbi  = 3'd4,
        wsel_slbi = 3'd5
    } wr_sel_e;

    typedef struct packed {
        op_e                   op;
        wr_sel_e               wr_sel;
        reg_idx_t              rs;
        reg_idx_t              rt;
        reg_idx_t              rd;
        logic                  has_rt; // rt is a real source
        logic                  wr_en;  // writes rd at wb
        logic [IMM_WIDTH-1:0]  imm;
    } decoded_op_t;

endpackage

//--- mem_stage.sv
// ########################################
// MEM stage: small data memory and the MEM/WB register
// stores write at the clock, loads read combinationally
// ########################################
`timescale 1ns/1ps
`include "pipe_macros.svh"

module mem_stage
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb
);

    localparam int ADDR_WIDTH = $clog2(`DMEM_DEPTH);

    word_t                  dmem [`DMEM_DEPTH];
    logic [ADDR_WIDTH-1:0]  addr;
    word_t                  rd_data;

    assign addr = ex_mem.alu_res[ADDR_WIDTH-1:0]; // upper address bits ignored

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.op == op_st) begin
            dmem[addr] <= ex_mem.st_data;
        end
    end

    assign rd_data = (ex_mem.op == op_ld) ? dmem[addr] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.rd       <= ex_mem.rd;
            mem_wb.wr_en    <= ex_mem.wr_en;
            mem_wb.wr_sel   <= ex_mem.wr_sel;
            mem_wb.mem_res  <= rd_data;
            mem_wb.alu_res  <= ex_mem.alu_res;
            mem_wb.set_res  <= ex_mem.set_res;
            mem_wb.lbi_res  <= ex_mem.lbi_res;
            mem_wb.slbi_res <= ex_mem.slbi_res;
        end
    end

endmodule

//--- operand_fetch.sv
// ########################################
// operand read for an issued operation
// fills the ID/EX register every cycle
// ########################################
`timescale 1ns/1ps

module operand_fetch
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  decoded_op_t issue_op,
    input  wb_port_t    wb,
    output id_ex_t      id_ex
);

    word_t rs_val;
    word_t rt_val;

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (issue_op.rs),
        .rd_addr_b (issue_op.rt),
        .rd_data_a (rs_val),
        .rd_data_b (rt_val),
        .wr_en     (wb.valid),
        .wr_addr   (wb.rd),
        .wr_data   (wb.data)
    );

    always_ff @(posedge clk) begin
        if (rst || !issue_valid) begin
            id_ex <= '0; // bubble: op add with wr_en low, no store
        end else begin
            id_ex.dec    <= issue_op;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= rt_val;
        end
    end

endmodule

//--- pipe_backend.sv
// ########################################
// integer back end top, one operation issued per cycle
// wb shows each result the cycle before the register write
// ########################################
`timescale 1ns/1ps

module pipe_backend
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  decoded_op_t issue_op,
    output wb_port_t    wb
);

    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    operand_fetch u_operand_fetch (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .wb          (wb),
        .id_ex       (id_ex)
    );

    execute_unit u_execute_unit (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .mem_wb (mem_wb),
        .ex_mem (ex_mem)
    );

    mem_stage u_mem_stage (
        .clk    (clk),
        .rst    (rst),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    // writeback data select, feeds both the register file and the port
    always_comb begin
        wb.valid = mem_wb.wr_en;
        wb.rd    = mem_wb.rd;
        case (mem_wb.wr_sel)
            wsel_alu:  wb.data = mem_wb.alu_res;
            wsel_mem:  wb.data = mem_wb.mem_res;
            wsel_set:  wb.data = mem_wb.set_res;
            wsel_lbi:  wb.data = mem_wb.lbi_res;
            wsel_slbi: wb.data = mem_wb.slbi_res;
            default:   wb.data = '0;
        endcase
    end

endmodule

//--- pipe_macros.svh
// ########################################
// sizing defines for the integer back end
// include before any package or module that needs them
// ########################################
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

`define DATA_WIDTH 16 // machine word

`define REG_COUNT 8 // architectural registers, 3-bit index

// data memory words, indexed by the low address bits
`define DMEM_DEPTH 16

`endif

//--- reg_file.sv
// ########################################
// eight entry register file, 2 read / 1 write
// same-cycle write is visible on the read ports
// ########################################
`timescale 1ns/1ps
`include "pipe_macros.svh"

module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [$clog2(`REG_COUNT)-1:0]       rd_addr_a,
    input  logic [$clog2(`REG_COUNT)-1:0]       rd_addr_b,
    output logic [`DATA_WIDTH-1:0]              rd_data_a,
    output logic [`DATA_WIDTH-1:0]              rd_data_b,
    input  logic                                wr_en,
    input  logic [$clog2(`REG_COUNT)-1:0]       wr_addr,
    input  logic [`DATA_WIDTH-1:0]              wr_data
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through covers the distance three dependence
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

//--- sources.f
+incdir+.
isa_pkg.sv
stage_pkg.sv
reg_file.sv
operand_fetch.sv
forward.sv
execute_unit.sv
mem_stage.sv
pipe_backend.sv
tb_clock_gen.sv
tb_pipe_backend.sv

//--- stage_pkg.sv
// ########################################
// pipeline register layouts and the writeback port
// ########################################
`include "pipe_macros.svh"

package stage_pkg;
    import isa_pkg::*;

    typedef struct packed {
        decoded_op_t dec;
        word_t       rs_val; // register file values, before forwarding
        word_t       rt_val;
    } id_ex_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     wr_en;
        wr_sel_e  wr_sel;
        op_e      op;
        word_t    st_data;  // forwarded rt
        word_t    alu_res;  // address for ld and st
        word_t    set_res;
        word_t    lbi_res;
        word_t    slbi_res;
    } ex_mem_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     wr_en;
        wr_sel_e  wr_sel;
        word_t    mem_res;
        word_t    alu_res;
        word_t    set_res;
        word_t    lbi_res;
        word_t    slbi_res;
    } mem_wb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_port_t;

endpackage

//--- tb_clock_gen.sv
// ########################################
// testbench clock, 10 ns period
// reset held high for the first 16 rising edges
// ########################################
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int RST_CYCLES = 16;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0; // released on the 16th edge
    end

endmodule

//--- tb_pipe_backend.sv
// ########################################
// random program through the back end, checked against
// an in-order model of registers and data memory
// ########################################
`timescale 1ns/1ps
`include "pipe_macros.svh"

module tb_pipe_backend
    import isa_pkg::*;
    import stage_pkg::*;
();

    localparam int NUM_SLOTS  = 400;
    localparam int RST_CYCLES = 16;
    localparam int LIMIT      = RST_CYCLES + NUM_SLOTS + 10;
    localparam int MEM_AW     = $clog2(`DMEM_DEPTH);

    logic        clk;
    logic        rst;
    logic        issue_valid;
    decoded_op_t issue_op;
    wb_port_t    wb;

    logic [31:0] lfsr_state = 32'h6db9ea80;
    word_t       arch_regs [`REG_COUNT];
    word_t       arch_mem [`DMEM_DEPTH];
    wb_port_t    exp_q [$];
    int          due_q [$]; // cycle at which each result must show on wb
    int          cyc = 0;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    pipe_backend UUT (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .wb          (wb)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // avoid keeps a load's destination away from the very next slot
    function automatic decoded_op_t random_op(input logic avoid_en, input reg_idx_t avoid);
        decoded_op_t op;
        logic [31:0] r;
        r = rand_bits(3);
        op.rs = r[2:0];
        r = rand_bits(3);
        op.rt = r[2:0];
        r = rand_bits(3);
        op.rd = r[2:0];
        r = rand_bits(8);
        op.imm = r[7:0];
        op.op = op_add;
        op.wr_sel = wsel_alu;
        op.has_rt = 1'b1;
        op.wr_en = 1'b1;
        r = rand_bits(3);
        case (r[2:0])
            3'd0: op.op = op_add;
            3'd1: op.op = op_sub;
            3'd2: op.op = op_xor;
            3'd3: op.op = op_and;
            3'd4: begin
                r = rand_bits(1);
                op.op = r[0] ? op_slt : op_seq;
                op.wr_sel = wsel_set;
            end
            3'd5: begin
                op.wr_sel = wsel_lbi;
                op.has_rt = 1'b0;
            end
            3'd6: begin
                op.wr_sel = wsel_slbi;
                op.has_rt = 1'b0;
            end
            default: begin
                r = rand_bits(1);
                if (r[0]) begin
                    op.op = op_st; // rd field is random but never written
                    op.wr_en = 1'b0;
                end else begin
                    op.op = op_ld;
                    op.wr_sel = wsel_mem;
                    op.has_rt = 1'b0;
                end
            end
        endcase
        if (avoid_en && op.rs == avoid) begin
            op.rs = op.rs + 3'd1;
        end
        if (avoid_en && op.has_rt && op.rt == avoid) begin
            op.rt = op.rt + 3'd1;
        end
        return op;
    endfunction

    // architectural result of one operation in program order
    function automatic wb_port_t model_op(input decoded_op_t op);
        wb_port_t         res;
        word_t            a;
        word_t            b;
        word_t            sext;
        word_t            ea;
        logic [MEM_AW-1:0] addr;
        a = arch_regs[op.rs];
        b = arch_regs[op.rt];
        sext = {{8{op.imm[7]}}, op.imm};
        ea = a + sext;
        addr = ea[MEM_AW-1:0];
        res.valid = op.wr_en;
        res.rd = op.rd;
        case (op.wr_sel)
            wsel_alu: begin
                case (op.op)
                    op_add:  res.data = a + b;
                    op_sub:  res.data = a - b;
                    op_xor:  res.data = a ^ b;
                    op_and:  res.data = a & b;
                    default: res.data = '0;
                endcase
            end
            wsel_mem:  res.data = arch_mem[addr];
            wsel_set: begin
                if (op.op == op_seq) begin
                    res.data = {15'd0, a == b};
                end else begin
                    res.data = {15'd0, $signed(a) < $signed(b)};
                end
            end
            wsel_lbi:  res.data = sext;
            wsel_slbi: res.data = {a[7:0], op.imm};
            default:   res.data = '0;
        endcase
        if (op.op == op_st) begin
            arch_mem[addr] = b;
        end
        if (op.wr_en) begin
            arch_regs[op.rd] = res.data;
        end
        return res;
    endfunction

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > LIMIT) begin
            report_fail("timeout: the run did not finish within the cycle limit");
        end
    end

    // outputs compared at the falling edge, half a cycle after they change
    always @(negedge clk) begin
        wb_port_t head;
        int       due;
        if (wb.valid) begin
            assert (exp_q.size() != 0)
                else report_fail("writeback seen with no operation pending");
            head = exp_q.pop_front();
            due = due_q.pop_front();
            assert (cyc == due)
                else report_fail("writeback arrived in the wrong cycle");
            assert (wb.rd == head.rd)
                else report_fail($sformatf("error: wb.rd got %h expected %h", wb.rd, head.rd));
            assert (wb.data == head.data)
                else report_fail($sformatf("error: wb.data got %h expected %h",
                                           wb.data, head.data));
        end else if (due_q.size() != 0) begin
            assert (due_q[0] != cyc)
                else report_fail("expected writeback did not appear");
        end
    end

    initial begin
        decoded_op_t op;
        wb_port_t    expected;
        logic [31:0] r;
        logic        ld_pending;
        reg_idx_t    ld_rd;
        issue_valid = 1'b0;
        issue_op = '0;
        ld_pending = 1'b0;
        ld_rd = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            arch_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            arch_mem[i] = '0;
        end
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        for (int i = 0; i < NUM_SLOTS; i++) begin
            r = rand_bits(2);
            if (r[1:0] == 2'd0) begin
                issue_valid = 1'b0; // bubble
                issue_op = '0;
                ld_pending = 1'b0;
            end else begin
                op = random_op(ld_pending, ld_rd);
                expected = model_op(op);
                if (op.wr_en) begin
                    exp_q.push_back(expected);
                    due_q.push_back(cyc + 3);
                end
                ld_pending = (op.op == op_ld);
                ld_rd = op.rd;
                issue_valid = 1'b1;
                issue_op = op;
            end
            @(negedge clk);
        end
        issue_valid = 1'b0;
        issue_op = '0;
        // three stage latency plus a spare cycle, no stray writebacks allowed
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            report_fail("operations left without a writeback at the end");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
